// File: branch_compare.sv
`timescale 1ns/1ps
`default_nettype none

`include "bru_params.svh"

module branch_compare (
  input  logic [`BRU_XLEN-1:0] rdata1_i,
  input  logic [`BRU_XLEN-1:0] rdata2_i,
  output logic                 equal_o,
  output logic                 signed_less_o,
  output logic                 unsigned_less_o
);

  localparam int MSB = `BRU_XLEN - 1;

  logic         carry;
  logic [MSB:0] diff;
  logic         zero_f;
  logic         sign_f;
  logic         ovf_f;

  // a - b as a + ~b + 1
  assign {carry, diff} = {1'b0, rdata1_i} + {1'b0, ~rdata2_i} + {{`BRU_XLEN{1'b0}}, 1'b1};

  assign zero_f = ~(|diff);
  assign sign_f = diff[MSB];
  assign ovf_f  = (rdata1_i[MSB] != rdata2_i[MSB]) && (diff[MSB] != rdata1_i[MSB]);

  assign equal_o         = zero_f;
  assign signed_less_o   = sign_f ^ ovf_f;
  assign unsigned_less_o = ~carry;       // borrow out

endmodule

`default_nettype wire

// File: branch_resolve_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "bru_params.svh"

module branch_resolve_top import bru_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    inst_valid_i,
  input  logic [`BRU_XLEN-1:0]    pc_i,
  input  logic [31:0]             inst_i,
  input  logic                    pvalid_i,
  input  logic                    ptaken_i,
  input  logic [`BRU_XLEN-1:0]    ptarget_i,
  output logic                    rf_rena1_o,
  output logic [`BRU_REG_AW-1:0]  rf_raddr1_o,
  input  logic [`BRU_XLEN-1:0]    rf_rdata1_i,
  output logic                    rf_rena2_o,
  output logic [`BRU_REG_AW-1:0]  rf_raddr2_o,
  input  logic [`BRU_XLEN-1:0]    rf_rdata2_i,
  input  logic                    s_axi_awvalid_i,
  output logic                    s_axi_awready_o,
  input  logic [`BRU_AXI_AW-1:0]  s_axi_awaddr_i,
  input  logic                    s_axi_wvalid_i,
  output logic                    s_axi_wready_o,
  input  logic [`BRU_XLEN-1:0]    s_axi_wdata_i,
  input  logic [`BRU_XLEN/8-1:0]  s_axi_wstrb_i,
  output logic                    s_axi_bvalid_o,
  input  logic                    s_axi_bready_i,
  output logic [1:0]              s_axi_bresp_o,
  input  logic                    s_axi_arvalid_i,
  output logic                    s_axi_arready_o,
  input  logic [`BRU_AXI_AW-1:0]  s_axi_araddr_i,
  output logic                    s_axi_rvalid_o,
  input  logic                    s_axi_rready_i,
  output logic [`BRU_XLEN-1:0]    s_axi_rdata_o,
  output logic [1:0]              s_axi_rresp_o,
  output logic                    redirect_valid_o,
  output logic [`BRU_XLEN-1:0]    redirect_pc_o,
  output cause_e                  redirect_cause_o,
  output logic                    upd_valid_o,
  output logic [`BRU_XLEN-1:0]    upd_pc_o,
  output logic                    upd_taken_o,
  output logic [`BRU_XLEN-1:0]    upd_target_o
);

  logic                 csr_rena;
  logic [11:0]          csr_raddr;
  logic [`BRU_XLEN-1:0] csr_rdata;
  logic                 is_branch;
  logic                 fail;
  logic                 csr_flush;
  logic [`BRU_XLEN-1:0] csr_target;
  logic [`BRU_XLEN-1:0] wpc;
  logic                 wtaken;
  logic [`BRU_XLEN-1:0] wtarget;

  pre_decode u_pre_decode (
    .pvalid_i     (pvalid_i),
    .ptaken_i     (ptaken_i),
    .ptarget_i    (ptarget_i),
    .pc_i         (pc_i),
    .inst_i       (inst_i),
    .rf_rena1_o   (rf_rena1_o),
    .rf_raddr1_o  (rf_raddr1_o),
    .rf_rdata1_i  (rf_rdata1_i),
    .rf_rena2_o   (rf_rena2_o),
    .rf_raddr2_o  (rf_raddr2_o),
    .rf_rdata2_i  (rf_rdata2_i),
    .csr_rena_o   (csr_rena),
    .csr_raddr_o  (csr_raddr),
    .csr_rdata_i  (csr_rdata),
    .is_branch_o  (is_branch),
    .is_csr_o     (),                    // classification only
    .fail_o       (fail),
    .csr_flush_o  (csr_flush),
    .csr_target_o (csr_target),
    .wpc_o        (wpc),
    .wtaken_o     (wtaken),
    .wtarget_o    (wtarget)
  );

  csr_trap_regs u_csr_trap_regs (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .csr_rena_i      (csr_rena),
    .csr_raddr_i     (csr_raddr),
    .csr_rdata_o     (csr_rdata),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wstrb_i   (s_axi_wstrb_i),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o)
  );

  redirect_merge u_redirect_merge (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .inst_valid_i     (inst_valid_i),
    .pvalid_i         (pvalid_i),
    .is_branch_i      (is_branch),
    .fail_i           (fail),
    .csr_flush_i      (csr_flush),
    .csr_target_i     (csr_target),
    .wpc_i            (wpc),
    .wtaken_i         (wtaken),
    .wtarget_i        (wtarget),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o),
    .redirect_cause_o (redirect_cause_o),
    .upd_valid_o      (upd_valid_o),
    .upd_pc_o         (upd_pc_o),
    .upd_taken_o      (upd_taken_o),
    .upd_target_o     (upd_target_o)
  );

endmodule

`default_nettype wire

// File: bru_params.svh
`ifndef BRU_PARAMS_SVH
`define BRU_PARAMS_SVH

// datapath
`define BRU_XLEN        32
`define BRU_REG_AW      5

// trap CSR reset values
`define BRU_MTVEC_RST   32'h0000_0100
`define BRU_MEPC_RST    32'h0000_0000

// AXI4-Lite register map
`define BRU_AXI_AW      4
`define BRU_OFF_MTVEC   4'h0
`define BRU_OFF_MEPC    4'h4

// CSR numbers on the side read port
`define BRU_CSR_MTVEC   12'h305
`define BRU_CSR_MEPC    12'h341

`endif

// File: bru_pkg.sv
`default_nettype none

package bru_pkg;

  // resolved control-flow operation
  typedef enum logic [3:0] {
    NOP  = 4'd0,
    BEQ  = 4'd1,
    BNE  = 4'd2,
    BLT  = 4'd3,
    BGE  = 4'd4,
    BLTU = 4'd5,
    BGEU = 4'd6,
    JAL  = 4'd7,
    JALR = 4'd8
  } bpu_op_e;

  // why the fetch unit is redirected
  typedef enum logic [1:0] {
    NONE   = 2'd0,
    BRANCH = 2'd1,
    CSR    = 2'd2
  } cause_e;

endpackage

`default_nettype wire

// File: compile.f
+incdir+.
bru_pkg.sv
branch_compare.sv
pre_decode.sv
csr_trap_regs.sv
redirect_merge.sv
branch_resolve_top.sv
tb_clock_gen.sv
tb_branch_resolve.sv

// File: csr_trap_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "bru_params.svh"

module csr_trap_regs (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    csr_rena_i,
  input  logic [11:0]             csr_raddr_i,
  output logic [`BRU_XLEN-1:0]    csr_rdata_o,
  input  logic                    s_axi_awvalid_i,
  output logic                    s_axi_awready_o,
  input  logic [`BRU_AXI_AW-1:0]  s_axi_awaddr_i,
  input  logic                    s_axi_wvalid_i,
  output logic                    s_axi_wready_o,
  input  logic [`BRU_XLEN-1:0]    s_axi_wdata_i,
  input  logic [`BRU_XLEN/8-1:0]  s_axi_wstrb_i,
  output logic                    s_axi_bvalid_o,
  input  logic                    s_axi_bready_i,
  output logic [1:0]              s_axi_bresp_o,
  input  logic                    s_axi_arvalid_i,
  output logic                    s_axi_arready_o,
  input  logic [`BRU_AXI_AW-1:0]  s_axi_araddr_i,
  output logic                    s_axi_rvalid_o,
  input  logic                    s_axi_rready_i,
  output logic [`BRU_XLEN-1:0]    s_axi_rdata_o,
  output logic [1:0]              s_axi_rresp_o
);

  localparam int         XLEN        = `BRU_XLEN;
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic            bvalid;
  logic            rvalid;
  logic            wr_accept;
  logic            rd_accept;
  logic            aw_mtvec;
  logic            aw_mepc;
  logic            ar_mtvec;
  logic            ar_mepc;

  function automatic logic [XLEN-1:0] merge_strb(
    input logic [XLEN-1:0]   cur,
    input logic [XLEN-1:0]   data,
    input logic [XLEN/8-1:0] strb
  );
    logic [XLEN-1:0] res;
    res = cur;
    for (int i = 0; i < XLEN/8; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = data[8*i +: 8];
      end
    end
    return res;
  endfunction

  // ------------------------------------------------------------------
  // write channel, AW and W taken together
  // ------------------------------------------------------------------
  assign wr_accept       = s_axi_awvalid_i && s_axi_wvalid_i && !bvalid;
  assign s_axi_awready_o = wr_accept;
  assign s_axi_wready_o  = wr_accept;
  assign aw_mtvec        = (s_axi_awaddr_i == `BRU_OFF_MTVEC);
  assign aw_mepc         = (s_axi_awaddr_i == `BRU_OFF_MEPC);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtvec  <= `BRU_MTVEC_RST;
      mepc   <= `BRU_MEPC_RST;
      bvalid <= 1'b0;
    end else if (wr_accept) begin
      if (aw_mtvec) begin
        mtvec <= merge_strb(mtvec, s_axi_wdata_i, s_axi_wstrb_i);
      end
      if (aw_mepc) begin
        mepc <= merge_strb(mepc, s_axi_wdata_i, s_axi_wstrb_i);
      end
      bvalid <= 1'b1;
    end else if (s_axi_bready_i) begin
      bvalid <= 1'b0;                     // response taken
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      s_axi_bresp_o <= (aw_mtvec || aw_mepc) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign s_axi_bvalid_o = bvalid;

  // ------------------------------------------------------------------
  // read channel
  // ------------------------------------------------------------------
  assign rd_accept       = s_axi_arvalid_i && !rvalid;
  assign s_axi_arready_o = !rvalid;
  assign ar_mtvec        = (s_axi_araddr_i == `BRU_OFF_MTVEC);
  assign ar_mepc         = (s_axi_araddr_i == `BRU_OFF_MEPC);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid <= 1'b0;
    end else if (rd_accept) begin
      rvalid <= 1'b1;
    end else if (s_axi_rready_i) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      s_axi_rdata_o <= ar_mtvec ? mtvec : ar_mepc ? mepc : '0;
      s_axi_rresp_o <= (ar_mtvec || ar_mepc) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign s_axi_rvalid_o = rvalid;

  // side port for the pre-decoder
  always_comb begin
    csr_rdata_o = '0;
    if (csr_rena_i) begin
      case (csr_raddr_i)
        `BRU_CSR_MTVEC: csr_rdata_o = mtvec;
        `BRU_CSR_MEPC:  csr_rdata_o = mepc;
        default:        csr_rdata_o = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: pre_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "bru_params.svh"

module pre_decode import bru_pkg::*; (
  input  logic                   pvalid_i,
  input  logic                   ptaken_i,
  input  logic [`BRU_XLEN-1:0]   ptarget_i,
  input  logic [`BRU_XLEN-1:0]   pc_i,
  input  logic [31:0]            inst_i,
  output logic                   rf_rena1_o,
  output logic [`BRU_REG_AW-1:0] rf_raddr1_o,
  input  logic [`BRU_XLEN-1:0]   rf_rdata1_i,
  output logic                   rf_rena2_o,
  output logic [`BRU_REG_AW-1:0] rf_raddr2_o,
  input  logic [`BRU_XLEN-1:0]   rf_rdata2_i,
  output logic                   csr_rena_o,
  output logic [11:0]            csr_raddr_o,
  input  logic [`BRU_XLEN-1:0]   csr_rdata_i,
  output logic                   is_branch_o,
  output logic                   is_csr_o,
  output logic                   fail_o,
  output logic                   csr_flush_o,
  output logic [`BRU_XLEN-1:0]   csr_target_o,
  output logic [`BRU_XLEN-1:0]   wpc_o,
  output logic                   wtaken_o,
  output logic [`BRU_XLEN-1:0]   wtarget_o
);

  localparam int              XLEN      = `BRU_XLEN;
  localparam logic [6:0]      OP_BRANCH = 7'b1100011;
  localparam logic [6:0]      OP_JAL    = 7'b1101111;
  localparam logic [6:0]      OP_JALR   = 7'b1100111;
  localparam logic [6:0]      OP_SYSTEM = 7'b1110011;
  localparam logic [XLEN-1:0] PC_STEP   = 4;

  // ------------------------------------------------------------------
  // field extraction
  // ------------------------------------------------------------------
  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [11:0]            funct12;
  logic [`BRU_REG_AW-1:0] rs1;
  logic [`BRU_REG_AW-1:0] rs2;
  logic [XLEN-1:0]        imm_i;
  logic [XLEN-1:0]        imm_b;
  logic [XLEN-1:0]        imm_j;
  logic [XLEN-1:0]        imm;
  bpu_op_e                bpu_op;
  logic                   cond_br;
  logic                   is_system;
  logic                   ecall;
  logic                   ebreak;
  logic                   mret;
  logic                   csrrw;
  logic                   csrrs;
  logic                   equal;
  logic                   signed_less;
  logic                   unsigned_less;
  logic                   taken;
  logic [XLEN-1:0]        target;

  assign opcode  = inst_i[6:0];
  assign funct3  = inst_i[14:12];
  assign funct12 = inst_i[31:20];
  assign rs1     = inst_i[19:15];
  assign rs2     = inst_i[24:20];

  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  always_comb begin
    bpu_op = NOP;
    case (opcode)
      OP_BRANCH: begin
        case (funct3)
          3'b000:  bpu_op = BEQ;
          3'b001:  bpu_op = BNE;
          3'b100:  bpu_op = BLT;
          3'b101:  bpu_op = BGE;
          3'b110:  bpu_op = BLTU;
          3'b111:  bpu_op = BGEU;
          default: bpu_op = NOP;
        endcase
      end
      OP_JAL:  bpu_op = JAL;
      OP_JALR: bpu_op = (funct3 == 3'b000) ? JALR : NOP;
      default: bpu_op = NOP;
    endcase
  end

  assign cond_br   = bpu_op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};
  assign is_system = (opcode == OP_SYSTEM);
  assign ecall     = is_system && (funct3 == 3'b000) && (funct12 == 12'h000);
  assign ebreak    = is_system && (funct3 == 3'b000) && (funct12 == 12'h001);
  assign mret      = is_system && (funct3 == 3'b000) && (funct12 == 12'h302);
  assign csrrw     = is_system && (funct3 == 3'b001);
  assign csrrs     = is_system && (funct3 == 3'b010);

  assign imm = cond_br         ? imm_b :
               (bpu_op == JAL)  ? imm_j :
               (bpu_op == JALR) ? imm_i : '0;

  branch_compare u_branch_compare (
    .rdata1_i        (rf_rdata1_i),
    .rdata2_i        (rf_rdata2_i),
    .equal_o         (equal),
    .signed_less_o   (signed_less),
    .unsigned_less_o (unsigned_less)
  );

  // ------------------------------------------------------------------
  // true direction and target
  // ------------------------------------------------------------------
  always_comb begin
    case (bpu_op)
      BEQ:       taken = equal;
      BNE:       taken = ~equal;
      BLT:       taken = signed_less;
      BGE:       taken = ~signed_less;
      BLTU:      taken = unsigned_less;
      BGEU:      taken = ~unsigned_less;
      JAL, JALR: taken = 1'b1;
      default:   taken = 1'b0;
    endcase
  end

  always_comb begin
    if (bpu_op == JALR) begin
      target = rf_rdata1_i + imm;       // register relative
    end else if (taken) begin
      target = pc_i + imm;
    end else begin
      target = pc_i + PC_STEP;          // fall through
    end
  end

  assign rf_rena1_o  = cond_br || (bpu_op == JALR);
  assign rf_raddr1_o = rs1;
  assign rf_rena2_o  = cond_br;
  assign rf_raddr2_o = rs2;

  assign csr_rena_o  = ecall || mret;
  assign csr_raddr_o = ecall ? `BRU_CSR_MTVEC :
                       mret  ? `BRU_CSR_MEPC  : 12'h000;

  assign is_branch_o  = (bpu_op != NOP);
  assign is_csr_o     = ecall || ebreak || mret || csrrw || csrrs;
  assign csr_flush_o  = ecall || mret;
  assign csr_target_o = csr_flush_o ? csr_rdata_i : '0;

  assign wpc_o     = pc_i;
  assign wtaken_o  = taken;
  assign wtarget_o = target;
  assign fail_o    = !(pvalid_i && (ptaken_i == taken) && (ptarget_i == target));

endmodule

`default_nettype wire

// File: redirect_merge.sv
`timescale 1ns/1ps
`default_nettype none

`include "bru_params.svh"

module redirect_merge import bru_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 inst_valid_i,
  input  logic                 pvalid_i,
  input  logic                 is_branch_i,
  input  logic                 fail_i,
  input  logic                 csr_flush_i,
  input  logic [`BRU_XLEN-1:0] csr_target_i,
  input  logic [`BRU_XLEN-1:0] wpc_i,
  input  logic                 wtaken_i,
  input  logic [`BRU_XLEN-1:0] wtarget_i,
  output logic                 redirect_valid_o,
  output logic [`BRU_XLEN-1:0] redirect_pc_o,
  output cause_e               redirect_cause_o,
  output logic                 upd_valid_o,
  output logic [`BRU_XLEN-1:0] upd_pc_o,
  output logic                 upd_taken_o,
  output logic [`BRU_XLEN-1:0] upd_target_o
);

  logic csr_hit;
  logic br_hit;

  assign csr_hit = inst_valid_i && csr_flush_i;
  assign br_hit  = inst_valid_i && fail_i && (is_branch_i || pvalid_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      redirect_valid_o <= 1'b0;
      redirect_cause_o <= NONE;
      upd_valid_o      <= 1'b0;
    end else begin
      redirect_valid_o <= csr_hit || br_hit;
      redirect_cause_o <= csr_hit ? CSR : (br_hit ? BRANCH : NONE);   // trap wins
      upd_valid_o      <= inst_valid_i && is_branch_i;
    end
  end

  always_ff @(posedge clk_i) begin
    redirect_pc_o <= csr_hit ? csr_target_i : wtarget_i;
    upd_pc_o      <= wpc_i;
    upd_taken_o   <= wtaken_i;
    upd_target_o  <= wtarget_i;
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_branch_resolve -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

echo "$out" | grep -q "TESTS PASSED"

// File: tb_branch_resolve.sv
`timescale 1ns/1ps
`default_nettype none

`include "bru_params.svh"

module tb_branch_resolve import bru_pkg::*; ();

  localparam int TIMEOUT = 50;

  logic        clk;
  logic        rst;
  logic        inst_valid;
  logic [31:0] pc;
  logic [31:0] inst;
  logic        pvalid;
  logic        ptaken;
  logic [31:0] ptarget;
  logic        rf_rena1;
  logic [4:0]  rf_raddr1;
  logic [31:0] rf_rdata1;
  logic        rf_rena2;
  logic [4:0]  rf_raddr2;
  logic [31:0] rf_rdata2;
  logic        awvalid;
  logic        awready;
  logic [3:0]  awaddr;
  logic        wvalid;
  logic        wready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        bvalid;
  logic        bready;
  logic [1:0]  bresp;
  logic        arvalid;
  logic        arready;
  logic [3:0]  araddr;
  logic        rvalid;
  logic        rready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        redirect_valid;
  logic [31:0] redirect_pc;
  cause_e      redirect_cause;
  logic        upd_valid;
  logic [31:0] upd_pc;
  logic        upd_taken;
  logic [31:0] upd_target;

  logic [31:0] rf [32];                 // register file model
  logic [31:0] exp_mtvec;
  logic [31:0] exp_mepc;
  logic [2:0]  f3_list [6];
  int          seed;
  int          mismatches;
  int          failures;

  assign rf_rdata1 = rf[rf_raddr1];
  assign rf_rdata2 = rf[rf_raddr2];

  tb_clock_gen u_clock_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  branch_resolve_top UUT (
    .clk_i (clk), .rst_i (rst),
    .inst_valid_i (inst_valid), .pc_i (pc), .inst_i (inst),
    .pvalid_i (pvalid), .ptaken_i (ptaken), .ptarget_i (ptarget),
    .rf_rena1_o (rf_rena1), .rf_raddr1_o (rf_raddr1), .rf_rdata1_i (rf_rdata1),
    .rf_rena2_o (rf_rena2), .rf_raddr2_o (rf_raddr2), .rf_rdata2_i (rf_rdata2),
    .s_axi_awvalid_i (awvalid), .s_axi_awready_o (awready), .s_axi_awaddr_i (awaddr),
    .s_axi_wvalid_i (wvalid), .s_axi_wready_o (wready),
    .s_axi_wdata_i (wdata), .s_axi_wstrb_i (wstrb),
    .s_axi_bvalid_o (bvalid), .s_axi_bready_i (bready), .s_axi_bresp_o (bresp),
    .s_axi_arvalid_i (arvalid), .s_axi_arready_o (arready), .s_axi_araddr_i (araddr),
    .s_axi_rvalid_o (rvalid), .s_axi_rready_i (rready),
    .s_axi_rdata_o (rdata), .s_axi_rresp_o (rresp),
    .redirect_valid_o (redirect_valid), .redirect_pc_o (redirect_pc),
    .redirect_cause_o (redirect_cause),
    .upd_valid_o (upd_valid), .upd_pc_o (upd_pc),
    .upd_taken_o (upd_taken), .upd_target_o (upd_target)
  );

  // ----------------------------------------------------------------------
  // checking helpers
  // ----------------------------------------------------------------------
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
      mismatches++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("ERROR t=%0t %s", $time, what);
    failures++;
  endtask

  function automatic logic [31:0] apply_strb(input logic [31:0] cur, input logic [31:0] d,
                                             input logic [3:0] s);
    logic [31:0] res;
    res = cur;
    for (int i = 0; i < 4; i++) begin
      if (s[i]) res[8*i +: 8] = d[8*i +: 8];
    end
    return res;
  endfunction

  // instruction encoders
  function automatic logic [31:0] enc_branch(input logic [2:0] f3, input logic [4:0] a,
                                             input logic [4:0] b, input logic [12:0] imm);
    return {imm[12], imm[10:5], b, a, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
  endfunction

  function automatic logic [31:0] enc_jalr(input logic [4:0] a, input logic [11:0] imm);
    return {imm, a, 3'b000, 5'd1, 7'b1100111};
  endfunction

  // ----------------------------------------------------------------------
  // instruction slot
  // ----------------------------------------------------------------------
  task automatic run_inst(input logic [31:0] ipc, input logic [31:0] iw, input logic pv,
                          input logic pt, input logic [31:0] ptgt, input logic is_br,
                          input logic flush, input logic [31:0] flush_tgt,
                          input logic taken, input logic [31:0] target);
    logic fail;
    logic exp_redir;
    logic reads_rs1;
    logic reads_rs2;
    fail      = !(pv && (pt == taken) && (ptgt == target));
    exp_redir = flush || (fail && (is_br || pv));
    reads_rs2 = (iw[6:0] == 7'b1100011);               // conditional branches
    reads_rs1 = reads_rs2 || (iw[6:0] == 7'b1100111);  // and JALR
    @(posedge clk);
    inst_valid <= 1'b1;
    pc         <= ipc;
    inst       <= iw;
    pvalid     <= pv;
    ptaken     <= pt;
    ptarget    <= ptgt;
    @(posedge clk);
    inst_valid <= 1'b0;
    #1;
    check_val("rf_rena1_o", {31'd0, rf_rena1}, {31'd0, reads_rs1});
    check_val("rf_rena2_o", {31'd0, rf_rena2}, {31'd0, reads_rs2});
    check_val("redirect_valid_o", {31'd0, redirect_valid}, {31'd0, exp_redir});
    check_val("upd_valid_o", {31'd0, upd_valid}, {31'd0, is_br});
    if (exp_redir) begin
      check_val("redirect_pc_o", redirect_pc, flush ? flush_tgt : target);
      check_val("redirect_cause_o", {30'd0, redirect_cause},
                {30'd0, flush ? CSR : BRANCH});
    end else begin
      check_val("redirect_cause_o", {30'd0, redirect_cause}, {30'd0, NONE});
    end
    if (is_br) begin
      check_val("upd_pc_o", upd_pc, ipc);
      check_val("upd_taken_o", {31'd0, upd_taken}, {31'd0, taken});
      check_val("upd_target_o", upd_target, target);
    end
  endtask

  // correct prediction half the time, otherwise random
  task automatic make_pred(input logic taken, input logic [31:0] target, output logic pv,
                           output logic pt, output logic [31:0] ptgt);
    logic [31:0] r;
    r = $random(seed);
    if (r[0]) begin
      pv   = 1'b1;
      pt   = taken;
      ptgt = target;
    end else begin
      pv   = r[1];
      pt   = r[2];
      ptgt = r[3] ? target : $random(seed);
    end
  endtask

  task automatic run_branch(input logic [2:0] f3, input logic [4:0] a, input logic [4:0] b,
                            input logic predict);
    logic [31:0] r;
    logic [31:0] ipc;
    logic [12:0] imm;
    logic [31:0] sx;
    logic        taken;
    logic [31:0] target;
    logic        pv;
    logic        pt;
    logic [31:0] ptgt;
    r   = $random(seed);
    ipc = {r[31:2], 2'b00};
    r   = $random(seed);
    imm = {r[12:1], 1'b0};
    sx  = {{19{imm[12]}}, imm};
    case (f3)
      3'b000:  taken = (rf[a] == rf[b]);
      3'b001:  taken = (rf[a] != rf[b]);
      3'b100:  taken = ($signed(rf[a]) < $signed(rf[b]));
      3'b101:  taken = ($signed(rf[a]) >= $signed(rf[b]));
      3'b110:  taken = (rf[a] < rf[b]);
      default: taken = (rf[a] >= rf[b]);
    endcase
    target = taken ? ipc + sx : ipc + 32'd4;
    pv = 1'b0;
    pt = 1'b0;
    ptgt = 32'd0;
    if (predict) make_pred(taken, target, pv, pt, ptgt);
    run_inst(ipc, enc_branch(f3, a, b, imm), pv, pt, ptgt, 1'b1, 1'b0, 32'd0, taken, target);
  endtask

  // ----------------------------------------------------------------------
  // AXI4-Lite master
  // ----------------------------------------------------------------------
  task automatic axi_write(input logic [3:0] addr, input logic [31:0] d, input logic [3:0] s,
                           input int hold, output logic [1:0] resp);
    int n;
    @(posedge clk);
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    awaddr  <= addr;
    wdata   <= d;
    wstrb   <= s;
    bready  <= (hold == 0);
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!(awready && wready) && n < TIMEOUT);
    if (n >= TIMEOUT) report_failure("write address/data handshake timed out");
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!bvalid && n < TIMEOUT);
    if (n >= TIMEOUT) report_failure("write response never arrived");
    resp = bresp;
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      if (!bvalid) report_failure("write response dropped while bready low");
      check_val("s_axi_bresp_o", {30'd0, bresp}, {30'd0, resp});
    end
    if (hold > 0) begin
      @(posedge clk);
      bready <= 1'b1;
    end
    @(posedge clk);
  endtask

  task automatic axi_read(input logic [3:0] addr, input int hold, output logic [31:0] d,
                          output logic [1:0] resp);
    int n;
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= addr;
    rready  <= (hold == 0);
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!arready && n < TIMEOUT);
    if (n >= TIMEOUT) report_failure("read address handshake timed out");
    @(posedge clk);
    arvalid <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!rvalid && n < TIMEOUT);
    if (n >= TIMEOUT) report_failure("read data never arrived");
    d    = rdata;
    resp = rresp;
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      if (!rvalid) report_failure("read data dropped while rready low");
      check_val("s_axi_rdata_o", rdata, d);
    end
    if (hold > 0) begin
      @(posedge clk);
      rready <= 1'b1;
    end
    @(posedge clk);
  endtask

  task automatic read_expect(input logic [3:0] addr, input logic [31:0] exp_d,
                             input logic [1:0] exp_resp, input int hold);
    logic [31:0] d;
    logic [1:0]  resp;
    axi_read(addr, hold, d, resp);
    check_val("s_axi_rresp_o", {30'd0, resp}, {30'd0, exp_resp});
    if (exp_resp == 2'b00) check_val("s_axi_rdata_o", d, exp_d);
  endtask

  task automatic write_expect(input logic [3:0] addr, input logic [31:0] d,
                              input logic [3:0] s, input logic [1:0] exp_resp, input int hold);
    logic [1:0] resp;
    axi_write(addr, d, s, hold, resp);
    check_val("s_axi_bresp_o", {30'd0, resp}, {30'd0, exp_resp});
    if (exp_resp == 2'b00) begin
      if (addr == `BRU_OFF_MTVEC) exp_mtvec = apply_strb(exp_mtvec, d, s);
      if (addr == `BRU_OFF_MEPC)  exp_mepc  = apply_strb(exp_mepc, d, s);
    end
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    logic [31:0] r;
    logic [31:0] ipc;
    logic [31:0] tgt;
    logic [20:0] jimm;
    logic [11:0] iimm;
    logic        pv;
    logic        pt;
    logic [31:0] ptgt;
    int          n;
    inst_valid = 1'b0;
    pc = '0;
    inst = '0;
    pvalid = 1'b0;
    ptaken = 1'b0;
    ptarget = '0;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    bready = 1'b1;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b1;
    mismatches = 0;
    failures = 0;
    seed = 32'h792c_cec2;
    f3_list = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    exp_mtvec = `BRU_MTVEC_RST;
    exp_mepc  = `BRU_MEPC_RST;
    rf[0] = '0;
    for (int i = 1; i < 32; i++) rf[i] = $random(seed);

    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (rst && n < TIMEOUT);
    if (n >= TIMEOUT) report_failure("reset never released");

    // reset state
    check_val("redirect_valid_o", {31'd0, redirect_valid}, 32'd0);
    check_val("upd_valid_o", {31'd0, upd_valid}, 32'd0);
    check_val("redirect_cause_o", {30'd0, redirect_cause}, {30'd0, NONE});
    check_val("s_axi_awready_o", {31'd0, awready}, 32'd0);    // low with no request
    check_val("s_axi_arready_o", {31'd0, arready}, 32'd1);
    read_expect(`BRU_OFF_MTVEC, `BRU_MTVEC_RST, 2'b00, 0);
    read_expect(`BRU_OFF_MEPC, `BRU_MEPC_RST, 2'b00, 0);

    // signed and unsigned edge operands
    rf[1] = 32'h8000_0000;
    rf[2] = 32'hFFFF_FFFF;
    rf[3] = 32'h0000_0000;
    rf[4] = 32'h7FFF_FFFF;
    rf[5] = 32'h0000_0001;
    for (int a = 1; a <= 5; a++) begin
      for (int b = 1; b <= 5; b++) begin
        for (int k = 0; k < 6; k++) run_branch(f3_list[k], a[4:0], b[4:0], 1'b0);
      end
    end

    // random conditional branches with random predictions
    repeat (200) begin
      r = $random(seed);
      run_branch(f3_list[r[2:0] % 6], r[12:8], r[20:16], 1'b1);
    end

    // JAL and JALR
    repeat (40) begin
      r    = $random(seed);
      ipc  = {r[31:2], 2'b00};
      r    = $random(seed);
      jimm = {r[20:1], 1'b0};
      tgt  = ipc + {{11{jimm[20]}}, jimm};
      make_pred(1'b1, tgt, pv, pt, ptgt);
      run_inst(ipc, enc_jal(jimm), pv, pt, ptgt, 1'b1, 1'b0, 32'd0, 1'b1, tgt);
    end
    repeat (40) begin
      r    = $random(seed);
      ipc  = {r[31:2], 2'b00};
      r    = $random(seed);
      iimm = r[11:0];
      tgt  = rf[r[24:20]] + {{20{iimm[11]}}, iimm};
      make_pred(1'b1, tgt, pv, pt, ptgt);
      run_inst(ipc, enc_jalr(r[24:20], iimm), pv, pt, ptgt, 1'b1, 1'b0, 32'd0, 1'b1, tgt);
    end

    // non-branch: no prediction, a correct fall-through prediction, then a wrong one
    run_inst(32'h0000_1000, 32'h0000_0013, 1'b0, 1'b1, 32'h0, 1'b0, 1'b0, 32'd0,
             1'b0, 32'h0000_1004);
    run_inst(32'h0000_2000, 32'h0000_0013, 1'b1, 1'b0, 32'h0000_2004, 1'b0, 1'b0, 32'd0,
             1'b0, 32'h0000_2004);
    run_inst(32'h0000_2800, 32'h0000_0013, 1'b1, 1'b1, 32'h0000_5000, 1'b0, 1'b0, 32'd0,
             1'b0, 32'h0000_2804);

    // trap CSRs with full and partial strobes
    write_expect(`BRU_OFF_MTVEC, 32'h8000_0040, 4'hF, 2'b00, 0);
    write_expect(`BRU_OFF_MEPC, 32'h1234_5678, 4'hF, 2'b00, 0);
    write_expect(`BRU_OFF_MEPC, 32'hAABB_CCDD, 4'b0101, 2'b00, 0);
    write_expect(`BRU_OFF_MTVEC, 32'h0000_9900, 4'b0010, 2'b00, 0);
    read_expect(`BRU_OFF_MTVEC, exp_mtvec, 2'b00, 0);
    read_expect(`BRU_OFF_MEPC, exp_mepc, 2'b00, 0);
    run_inst(32'h0000_3000, 32'h0000_0073, 1'b1, 1'b1, 32'h0000_4444, 1'b0, 1'b1,
             exp_mtvec, 1'b0, 32'h0000_3004);
    run_inst(32'h0000_3100, 32'h3020_0073, 1'b1, 1'b1, 32'h0000_5555, 1'b0, 1'b1,
             exp_mepc, 1'b0, 32'h0000_3104);
    run_inst(32'h0000_3200, 32'h0000_0073, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1,
             exp_mtvec, 1'b0, 32'h0000_3204);

    // unmapped offset and held responses
    write_expect(4'h8, 32'hDEAD_BEEF, 4'hF, 2'b10, 0);
    write_expect(4'hC, 32'hDEAD_BEEF, 4'hF, 2'b10, 3);
    read_expect(`BRU_OFF_MTVEC, exp_mtvec, 2'b00, 4);
    read_expect(`BRU_OFF_MEPC, exp_mepc, 2'b00, 2);
    write_expect(`BRU_OFF_MEPC, 32'h0000_0A00, 4'hF, 2'b00, 3);
    read_expect(`BRU_OFF_MEPC, exp_mepc, 2'b00, 0);
    run_inst(32'h0000_3300, 32'h3020_0073, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1,
             exp_mepc, 1'b0, 32'h0000_3304);

    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;          // 10 ns period
  end

  initial begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire
